// File: common/rename_pkg.sv
package rename_pkg;

    // rename and retire slots per cycle
    localparam int rename_width = 2;

    localparam int arch_reg_count = 32;
    localparam int phys_reg_count = 64;  // also the depth of each free list

    localparam int areg_width = $clog2(arch_reg_count);
    localparam int prn_width = $clog2(phys_reg_count);
    localparam int fl_count_width = prn_width + 1;  // one extra bit so a full list fits

    typedef logic [areg_width-1:0] areg_t;
    typedef logic [prn_width-1:0] prn_t;
    typedef logic [prn_width-1:0] fl_ptr_t;
    typedef logic [fl_count_width-1:0] fl_count_t;

    // after reset physical registers 0..31 hold the architectural state,
    // so the free list starts with 32..63 between head and tail
    localparam fl_ptr_t fl_reset_head = fl_ptr_t'(arch_reg_count);
    localparam fl_ptr_t fl_reset_tail = fl_ptr_t'(0);
    localparam fl_count_t fl_reset_count = fl_count_t'(phys_reg_count - arch_reg_count);

    localparam fl_count_t fl_full_count = fl_count_t'(phys_reg_count);

    // advance a free-list pointer around the circular buffer
    function automatic fl_ptr_t fl_ptr_inc(fl_ptr_t ptr);
        fl_ptr_t result;
        if (ptr == fl_ptr_t'(phys_reg_count - 1)) begin
            result = '0;
        end else begin
            result = ptr + 1'b1;
        end
        return result;
    endfunction

    // reset mapping of architectural register i is physical register i
    function automatic prn_t reset_prn(int index);
        prn_t result;
        result = prn_t'(index);
        return result;
    endfunction

endpackage

// File: rename/free_list.sv
module free_list (
    input  logic                  clock,
    input  logic                  reset,

    input  logic                  pop_en [rename_pkg::rename_width],
    input  logic                  push_valid [rename_pkg::rename_width],
    input  rename_pkg::prn_t      push_prn [rename_pkg::rename_width],

    input  logic                  restore,
    input  rename_pkg::prn_t      restore_entries [rename_pkg::phys_reg_count],
    input  rename_pkg::fl_ptr_t   restore_head,
    input  rename_pkg::fl_ptr_t   restore_tail,
    input  rename_pkg::fl_count_t restore_count,

    output rename_pkg::prn_t      pop_prn [rename_pkg::rename_width],
    output logic                  pop_valid [rename_pkg::rename_width],
    output rename_pkg::prn_t      entries [rename_pkg::phys_reg_count],
    output rename_pkg::fl_ptr_t   head,
    output rename_pkg::fl_ptr_t   tail,
    output rename_pkg::fl_count_t count
);
    import rename_pkg::*;

    prn_t      next_entries [phys_reg_count];
    fl_ptr_t   next_head;
    fl_ptr_t   next_tail;
    fl_count_t next_count;

    // pops are served first in slot order, then pushes land at the tail
    always_comb begin
        next_entries = entries;
        next_head    = head;
        next_tail    = tail;
        next_count   = count;

        for (int i = 0; i < rename_width; i++) begin
            pop_prn[i]   = entries[next_head];
            pop_valid[i] = 1'b0;
            if (pop_en[i] && next_count != '0) begin
                pop_valid[i] = 1'b1;
                next_head    = fl_ptr_inc(next_head);
                next_count   = next_count - 1'b1;
            end
        end

        for (int i = 0; i < rename_width; i++) begin
            // a push into a full list is dropped
            if (push_valid[i] && next_count < fl_full_count) begin
                next_entries[next_tail] = push_prn[i];
                next_tail  = fl_ptr_inc(next_tail);
                next_count = next_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= fl_reset_head;
            tail  <= fl_reset_tail;
            count <= fl_reset_count;
            for (int i = 0; i < phys_reg_count; i++) begin
                entries[i] <= reset_prn(i);
            end
        end else if (restore) begin
            // whole state replaced in one cycle, pops and pushes of this cycle are lost
            entries <= restore_entries;
            head    <= restore_head;
            tail    <= restore_tail;
            count   <= restore_count;
        end else begin
            entries <= next_entries;
            head    <= next_head;
            tail    <= next_tail;
            count   <= next_count;
        end
    end

endmodule

// File: rename/map_table.sv
module map_table (
    input  logic                clock,
    input  logic                reset,

    input  logic                rename_valid [rename_pkg::rename_width],
    input  rename_pkg::areg_t   rename_areg [rename_pkg::rename_width],
    input  rename_pkg::prn_t    alloc_prn [rename_pkg::rename_width],
    input  logic                alloc_valid [rename_pkg::rename_width],

    input  logic                restore,
    input  rename_pkg::prn_t    restore_map [rename_pkg::arch_reg_count],

    output rename_pkg::prn_t    old_prn [rename_pkg::rename_width]
);
    import rename_pkg::*;

    prn_t map [arch_reg_count];  // speculative arch to phys mapping
    logic slot_renames [rename_width];

    // a slot changes the map only when it asked and got a register
    always_comb begin
        for (int i = 0; i < rename_width; i++) begin
            slot_renames[i] = rename_valid[i] && alloc_valid[i];
        end
    end

    // each slot sees the mapping in force just before it in program order,
    // so an older slot of the same group that wrote the register overrides the table
    always_comb begin
        for (int i = 0; i < rename_width; i++) begin
            old_prn[i] = map[rename_areg[i]];
            for (int j = 0; j < i; j++) begin
                if (slot_renames[j] && rename_areg[j] == rename_areg[i]) begin
                    old_prn[i] = alloc_prn[j];
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int a = 0; a < arch_reg_count; a++) begin
                map[a] <= reset_prn(a);
            end
        end else if (restore) begin
            map <= restore_map;  // back to the committed map
        end else begin
            // later slots are written last and win on the same register
            for (int i = 0; i < rename_width; i++) begin
                if (slot_renames[i]) begin
                    map[rename_areg[i]] <= alloc_prn[i];
                end
            end
        end
    end

endmodule

// File: rename/retire_map.sv
module retire_map (
    input  logic                  clock,
    input  logic                  reset,

    input  logic                  retire_valid [rename_pkg::rename_width],
    input  rename_pkg::areg_t     retire_areg [rename_pkg::rename_width],
    input  rename_pkg::prn_t      retire_prn [rename_pkg::rename_width],

    output logic                  freed_valid [rename_pkg::rename_width],
    output rename_pkg::prn_t      freed_prn [rename_pkg::rename_width],

    output rename_pkg::prn_t      committed_map [rename_pkg::arch_reg_count],
    output rename_pkg::prn_t      committed_entries [rename_pkg::phys_reg_count],
    output rename_pkg::fl_ptr_t   committed_head,
    output rename_pkg::fl_ptr_t   committed_tail,
    output rename_pkg::fl_count_t committed_count
);
    import rename_pkg::*;

    // the register a retiring slot replaces is dead once that slot commits,
    // slot 1 sees slot 0's commit when both retire the same register
    always_comb begin
        for (int i = 0; i < rename_width; i++) begin
            freed_valid[i] = retire_valid[i];
            freed_prn[i]   = committed_map[retire_areg[i]];
            for (int j = 0; j < i; j++) begin
                if (retire_valid[j] && retire_areg[j] == retire_areg[i]) begin
                    freed_prn[i] = retire_prn[j];
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int a = 0; a < arch_reg_count; a++) begin
                committed_map[a] <= reset_prn(a);
            end
        end else begin
            for (int i = 0; i < rename_width; i++) begin
                if (retire_valid[i]) begin
                    committed_map[retire_areg[i]] <= retire_prn[i];
                end
            end
        end
    end

    // committed copy of the free list
    // instructions retire in the order they were renamed, so each pop here
    // returns that slot's retire_prn and the popped value is not needed
    // restore is never raised; its inputs just loop the list's own state back
    free_list committed_list (
        .clock           (clock),
        .reset           (reset),
        .pop_en          (retire_valid),
        .push_valid      (freed_valid),
        .push_prn        (freed_prn),
        .restore         (1'b0),
        .restore_entries (committed_entries),
        .restore_head    (committed_head),
        .restore_tail    (committed_tail),
        .restore_count   (committed_count),
        .pop_prn         (),
        .pop_valid       (),
        .entries         (committed_entries),
        .head            (committed_head),
        .tail            (committed_tail),
        .count           (committed_count)
    );

endmodule

// File: logic/rename_unit.sv
module rename_unit (
    input  logic                  clock,
    input  logic                  reset,

    input  logic                  rename_valid [rename_pkg::rename_width],
    input  rename_pkg::areg_t     rename_areg [rename_pkg::rename_width],

    input  logic                  retire_valid [rename_pkg::rename_width],
    input  rename_pkg::areg_t     retire_areg [rename_pkg::rename_width],
    input  rename_pkg::prn_t      retire_prn [rename_pkg::rename_width],

    input  logic                  squash,

    output rename_pkg::prn_t      rename_prn [rename_pkg::rename_width],
    output logic                  rename_prn_valid [rename_pkg::rename_width],
    output rename_pkg::prn_t      rename_old_prn [rename_pkg::rename_width],
    output rename_pkg::fl_count_t free_count
);
    import rename_pkg::*;

    logic      spec_pop_valid [rename_width];
    logic      freed_valid [rename_width];
    prn_t      freed_prn [rename_width];

    prn_t      committed_map [arch_reg_count];
    prn_t      committed_entries [phys_reg_count];
    fl_ptr_t   committed_head;
    fl_ptr_t   committed_tail;
    fl_count_t committed_count;

    // nothing renamed in a squash cycle survives the restore
    always_comb begin
        for (int i = 0; i < rename_width; i++) begin
            rename_prn_valid[i] = spec_pop_valid[i] && !squash;
        end
    end

    free_list spec_list (
        .clock           (clock),
        .reset           (reset),
        .pop_en          (rename_valid),
        .push_valid      (freed_valid),
        .push_prn        (freed_prn),
        .restore         (squash),
        .restore_entries (committed_entries),
        .restore_head    (committed_head),
        .restore_tail    (committed_tail),
        .restore_count   (committed_count),
        .pop_prn         (rename_prn),
        .pop_valid       (spec_pop_valid),
        .entries         (),
        .head            (),
        .tail            (),
        .count           (free_count)
    );

    map_table spec_map (
        .clock        (clock),
        .reset        (reset),
        .rename_valid (rename_valid),
        .rename_areg  (rename_areg),
        .alloc_prn    (rename_prn),
        .alloc_valid  (spec_pop_valid),
        .restore      (squash),
        .restore_map  (committed_map),
        .old_prn      (rename_old_prn)
    );

    retire_map commit_state (
        .clock             (clock),
        .reset             (reset),
        .retire_valid      (retire_valid),
        .retire_areg       (retire_areg),
        .retire_prn        (retire_prn),
        .freed_valid       (freed_valid),
        .freed_prn         (freed_prn),
        .committed_map     (committed_map),
        .committed_entries (committed_entries),
        .committed_head    (committed_head),
        .committed_tail    (committed_tail),
        .committed_count   (committed_count)
    );

endmodule

// File: tests/clock_gen.sv
module clock_gen (
    output logic clock,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int half_period = 10;  // 20 ns clock
    localparam int reset_cycles = 5;

    initial begin
        clock = 1'b0;
        forever #half_period clock = ~clock;
    end

    // reset drops on the edge that ends the fifth cycle
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clock);
        reset <= 1'b0;
    end

endmodule

// File: tests/rename_unit_tb.sv
module rename_unit_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import rename_pkg::*;

    localparam int max_rows = 128;
    localparam int reset_cycles = 5;
    localparam int margin_cycles = 20;
    localparam int burst_rows = 48;

    typedef enum logic [1:0] {op_idle, op_rename, op_retire, op_squash} op_t;

    typedef struct packed {
        op_t         kind;
        logic [1:0]  ren_valid;
        areg_t [1:0] ren_areg;
        logic [1:0]  ret_valid;
        areg_t [1:0] ret_areg;
        prn_t [1:0]  ret_prn;
        prn_t [1:0]  exp_prn;
        logic [1:0]  exp_valid;
        prn_t [1:0]  exp_old;
        fl_count_t   exp_count;
    } row_t;

    logic      clock;
    logic      reset;
    logic      rename_valid [rename_width];
    areg_t     rename_areg [rename_width];
    logic      retire_valid [rename_width];
    areg_t     retire_areg [rename_width];
    prn_t      retire_prn [rename_width];
    logic      squash;
    prn_t      rename_prn [rename_width];
    logic      rename_prn_valid [rename_width];
    prn_t      rename_old_prn [rename_width];
    fl_count_t free_count;

    row_t rows [max_rows];
    int   row_count = 0;

    // reference state built alongside the table, speculative and committed
    prn_t  spec_map [arch_reg_count];
    prn_t  spec_list [phys_reg_count];
    int    spec_head;
    int    spec_tail;
    int    spec_count;
    prn_t  com_map [arch_reg_count];
    prn_t  com_list [phys_reg_count];
    int    com_head;
    int    com_tail;
    int    com_count;
    areg_t pend_areg [$];  // renamed and not yet retired, in program order
    prn_t  pend_prn [$];

    int prn_errors = 0;
    int valid_errors = 0;
    int count_errors = 0;
    int table_errors = 0;
    int cycle_count = 0;
    int cycle_limit = 0;
    int total_errors;

    clock_gen clocks (
        .clock (clock),
        .reset (reset)
    );

    rename_unit dut0 (
        .clock            (clock),
        .reset            (reset),
        .rename_valid     (rename_valid),
        .rename_areg      (rename_areg),
        .retire_valid     (retire_valid),
        .retire_areg      (retire_areg),
        .retire_prn       (retire_prn),
        .squash           (squash),
        .rename_prn       (rename_prn),
        .rename_prn_valid (rename_prn_valid),
        .rename_old_prn   (rename_old_prn),
        .free_count       (free_count)
    );

    task automatic add_to_table(input row_t r);
        if (row_count < max_rows) begin
            rows[row_count] = r;
            row_count++;
        end else begin
            $display("stimulus table overflow, a row was not added");
            table_errors++;
        end
    endtask

    task automatic idle_row();
        row_t r;
        r = '0;
        r.kind = op_idle;
        r.exp_count = fl_count_t'(spec_count);
        add_to_table(r);
    endtask

    task automatic rename_row(input logic v0, input areg_t a0, input logic v1, input areg_t a1);
        row_t r;
        r = '0;
        r.kind = op_rename;
        r.ren_valid = {v1, v0};
        r.ren_areg[0] = a0;
        r.ren_areg[1] = a1;
        r.exp_count = fl_count_t'(spec_count);
        for (int i = 0; i < rename_width; i++) begin
            if (r.ren_valid[i] && spec_count > 0) begin
                r.exp_valid[i] = 1'b1;
                r.exp_prn[i] = spec_list[spec_head];
                r.exp_old[i] = spec_map[r.ren_areg[i]];
                spec_map[r.ren_areg[i]] = spec_list[spec_head];  // slot 1 sees this write
                spec_head = (spec_head + 1) % phys_reg_count;
                spec_count--;
                pend_areg.push_back(r.ren_areg[i]);
                pend_prn.push_back(r.exp_prn[i]);
            end
        end
        add_to_table(r);
    endtask

    // retires the oldest n renamed instructions
    task automatic retire_row(input int n);
        row_t r;
        prn_t freed [rename_width];
        r = '0;
        r.kind = op_retire;
        r.exp_count = fl_count_t'(spec_count);
        for (int i = 0; i < n; i++) begin
            r.ret_valid[i] = 1'b1;
            r.ret_areg[i] = pend_areg.pop_front();
            r.ret_prn[i] = pend_prn.pop_front();
            freed[i] = com_map[r.ret_areg[i]];
            com_map[r.ret_areg[i]] = r.ret_prn[i];
            if (com_count > 0) begin
                com_head = (com_head + 1) % phys_reg_count;
                com_count--;
            end
        end
        // pushes land after the pops, in both lists
        for (int i = 0; i < n; i++) begin
            if (com_count < phys_reg_count) begin
                com_list[com_tail] = freed[i];
                com_tail = (com_tail + 1) % phys_reg_count;
                com_count++;
            end
            if (spec_count < phys_reg_count) begin
                spec_list[spec_tail] = freed[i];
                spec_tail = (spec_tail + 1) % phys_reg_count;
                spec_count++;
            end
        end
        add_to_table(r);
    endtask

    task automatic squash_row(input logic v0, input areg_t a0);
        row_t r;
        r = '0;
        r.kind = op_squash;
        r.ren_valid = {1'b0, v0};  // a rename in the squash cycle must not come out valid
        r.ren_areg[0] = a0;
        r.exp_count = fl_count_t'(spec_count);
        spec_map = com_map;
        spec_list = com_list;
        spec_head = com_head;
        spec_tail = com_tail;
        spec_count = com_count;
        pend_areg.delete();
        pend_prn.delete();
        add_to_table(r);
    endtask

    task automatic build_table();
        int    k;
        int    n;
        logic  v0;
        logic  v1;
        areg_t a0;
        areg_t a1;
        for (int a = 0; a < arch_reg_count; a++) begin
            spec_map[a] = prn_t'(a);
            com_map[a] = prn_t'(a);
        end
        for (int e = 0; e < phys_reg_count; e++) begin
            spec_list[e] = prn_t'(e);
            com_list[e] = prn_t'(e);
        end
        spec_head = arch_reg_count;
        com_head = arch_reg_count;
        spec_tail = 0;
        com_tail = 0;
        spec_count = phys_reg_count - arch_reg_count;
        com_count = spec_count;

        idle_row();
        rename_row(1'b1, 5'd3, 1'b1, 5'd7);
        rename_row(1'b1, 5'd5, 1'b1, 5'd5);
        rename_row(1'b1, 5'd10, 1'b0, 5'd0);  // leaves an odd count
        k = 0;
        while (spec_count > 1) begin
            rename_row(1'b1, areg_t'(k % 32), 1'b1, areg_t'((k + 9) % 32));
            k++;
        end
        rename_row(1'b1, 5'd12, 1'b1, 5'd13);
        rename_row(1'b1, 5'd14, 1'b1, 5'd15);
        idle_row();

        retire_row(2);
        retire_row(2);
        rename_row(1'b1, 5'd20, 1'b1, 5'd21);
        rename_row(1'b1, 5'd22, 1'b1, 5'd23);
        retire_row(1);
        squash_row(1'b1, 5'd4);
        rename_row(1'b1, 5'd3, 1'b1, 5'd7);
        idle_row();

        for (int b = 0; b < burst_rows; b++) begin
            if (($urandom % 2) == 0 && pend_prn.size() > 0) begin
                n = 1;
                if (pend_prn.size() > 1 && ($urandom % 2) == 1) begin
                    n = 2;
                end
                retire_row(n);
            end else begin
                v0 = (($urandom % 4) != 0);
                v1 = (($urandom % 4) != 0);
                a0 = areg_t'($urandom % arch_reg_count);
                a1 = areg_t'($urandom % arch_reg_count);
                rename_row(v0, a0, v1, a1);
            end
        end
        squash_row(1'b0, 5'd0);
        rename_row(1'b1, 5'd5, 1'b1, 5'd9);
        idle_row();
    endtask

    task automatic prn_check(input string name, input int idx, input prn_t got, input prn_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s row %0d: got 0x%h, expected 0x%h", name, idx, got, exp);
            prn_errors++;
        end
    endtask

    task automatic valid_check(input string name, input int idx, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s row %0d: got 0x%h, expected 0x%h", name, idx, got, exp);
            valid_errors++;
        end
    endtask

    task automatic count_check(input string name, input int idx, input fl_count_t got,
                               input fl_count_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s row %0d: got 0x%h, expected 0x%h", name, idx, got, exp);
            count_errors++;
        end
    endtask

    task automatic apply_row(input row_t r);
        for (int i = 0; i < rename_width; i++) begin
            rename_valid[i] <= r.ren_valid[i];
            rename_areg[i] <= r.ren_areg[i];
            retire_valid[i] <= r.ret_valid[i];
            retire_areg[i] <= r.ret_areg[i];
            retire_prn[i] <= r.ret_prn[i];
        end
        squash <= (r.kind == op_squash);
    endtask

    task automatic compare_row(input int idx, input row_t r);
        for (int i = 0; i < rename_width; i++) begin
            valid_check($sformatf("rename_prn_valid[%0d]", i), idx, rename_prn_valid[i],
                        r.exp_valid[i]);
            if (r.exp_valid[i]) begin
                prn_check($sformatf("rename_prn[%0d]", i), idx, rename_prn[i], r.exp_prn[i]);
                prn_check($sformatf("rename_old_prn[%0d]", i), idx, rename_old_prn[i],
                          r.exp_old[i]);
            end
        end
        count_check("free_count", idx, free_count, r.exp_count);
    endtask

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        for (int i = 0; i < rename_width; i++) begin
            rename_valid[i] = 1'b0;
            rename_areg[i] = '0;
            retire_valid[i] = 1'b0;
            retire_areg[i] = '0;
            retire_prn[i] = '0;
        end
        squash = 1'b0;
        void'($urandom(32'h8e6e));
        build_table();
        cycle_limit = row_count + reset_cycles + margin_cycles;

        @(negedge clock);
        while (reset) @(negedge clock);

        // outputs are combinational on the driven row, so sample mid cycle
        for (int idx = 0; idx < row_count; idx++) begin
            @(posedge clock);
            apply_row(rows[idx]);
            @(negedge clock);
            compare_row(idx, rows[idx]);
        end

        total_errors = prn_errors + valid_errors + count_errors + table_errors;
        $display("rows %0d, errors: prn %0d, valid %0d, count %0d, table %0d",
                 row_count, prn_errors, valid_errors, count_errors, table_errors);
        if (total_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: rename_unit.f
common/rename_pkg.sv
rename/free_list.sv
rename/map_table.sv
rename/retire_map.sv
logic/rename_unit.sv
tests/clock_gen.sv
tests/rename_unit_tb.sv
